// ==== lb_pkg.sv ====
package lb_pkg;

    // number of balanced regions, kept a power of two for the pairwise tree
    localparam int N_REGIONS = 4;
    localparam int REGION_IDX_BITS = 2;

    // one compare layer per index bit
    localparam int N_LAYERS = REGION_IDX_BITS;

    // pairs compared in the first layer
    localparam int N_PAIRS = N_REGIONS / 2;

    // layer counter inside the tree
    localparam int LAYER_BITS = (N_LAYERS > 1) ? $clog2(N_LAYERS) : 1;
    localparam logic [LAYER_BITS-1:0] LAST_LAYER = LAYER_BITS'(N_LAYERS - 1);

    // metadata queue sizing
    localparam int QDEPTH = 16;
    localparam int QPTR_BITS = $clog2(QDEPTH);
    localparam int QCNT_BITS = $clog2(QDEPTH + 1);
    localparam logic [QCNT_BITS-1:0] Q_FULL_CNT = QCNT_BITS'(QDEPTH);

    localparam int LOAD_BITS = 4;
    localparam int OID_BITS = 16;

    // request word is 48 bits of meta meta, 32 bits of method, 2 flags and the oid
    localparam int META_BITS = 98;
    localparam int META_OID_LSB = 0;

    typedef logic [META_BITS-1:0] meta_t;
    typedef logic [OID_BITS-1:0] oid_t;
    typedef logic [LOAD_BITS-1:0] load_t;
    typedef logic [REGION_IDX_BITS-1:0] region_idx_t;

    // status of one region, operator id on top and load at the bottom
    typedef struct packed {
        oid_t  oid;
        load_t load;
    } region_stat_t;

    // all regions on one bus, region 0 in the lowest bits
    typedef region_stat_t [N_REGIONS-1:0] region_stats_t;

endpackage

// ==== meta_fifo.sv ====
`timescale 1ns/100ps

module meta_fifo (
    input  logic          aclk,
    input  logic          aresetn,
    // push side
    input  logic          in_valid,
    output logic          in_ready,
    input  lb_pkg::meta_t in_meta,
    // show-ahead pop side
    output logic          head_valid,
    output lb_pkg::meta_t head_meta,
    input  logic          pop
);

    // storage ring
    lb_pkg::meta_t mem [lb_pkg::QDEPTH];

    logic [lb_pkg::QPTR_BITS-1:0] wr_ptr;
    logic [lb_pkg::QPTR_BITS-1:0] rd_ptr;
    logic [lb_pkg::QCNT_BITS-1:0] count;

    logic push_fire;
    logic pop_fire;

    // full only when every slot is taken
    assign in_ready = (count != lb_pkg::Q_FULL_CNT);
    assign head_valid = (count != '0);

    // oldest entry is always on the output
    assign head_meta = mem[rd_ptr];

    assign push_fire = in_valid && in_ready;
    // ignore a pop on an empty queue
    assign pop_fire = pop && head_valid;

    // pointers and occupancy
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // depth is a power of two so the pointers wrap by themselves
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                // push and pop together leave the count alone
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // data write
    always_ff @(posedge aclk) begin
        if (push_fire) begin
            mem[wr_ptr] <= in_meta;
        end
    end

endmodule

// ==== least_load_tree.sv ====
`timescale 1ns/100ps

module least_load_tree (
    input  logic                  aclk,
    input  logic                  aresetn,
    // one-cycle request to search
    input  logic                  start,
    input  lb_pkg::region_stats_t region_stats,
    input  lb_pkg::oid_t          req_oid,
    // one-cycle result strobe
    output logic                  done,
    output lb_pkg::region_idx_t   winner
);

    // snapshot taken on start, stable for the whole search
    lb_pkg::region_stats_t stats_q;
    lb_pkg::oid_t          oid_q;

    // candidate buffer, halved in place every layer
    lb_pkg::load_t       cand_load [lb_pkg::N_REGIONS];
    lb_pkg::region_idx_t cand_idx [lb_pkg::N_REGIONS];

    // survivors of the current layer
    lb_pkg::load_t       next_load [lb_pkg::N_PAIRS];
    lb_pkg::region_idx_t next_idx [lb_pkg::N_PAIRS];

    logic                          busy;
    logic [lb_pkg::LAYER_BITS-1:0] layer;
    logic                          last_layer;

    assign last_layer = (layer == lb_pkg::LAST_LAYER);

    // pairwise compare of neighbours 2p and 2p+1
    // pairs past the live part of the buffer produce values nobody reads
    always_comb begin
        for (int p = 0; p < lb_pkg::N_PAIRS; p++) begin
            if (cand_load[2*p] < cand_load[2*p+1]) begin
                next_load[p] = cand_load[2*p];
                next_idx[p]  = cand_idx[2*p];
            end else if (cand_load[2*p] > cand_load[2*p+1]) begin
                next_load[p] = cand_load[2*p+1];
                next_idx[p]  = cand_idx[2*p+1];
            end else if (stats_q[cand_idx[2*p]].oid == oid_q) begin
                // tie, left region already runs the operator
                next_load[p] = cand_load[2*p];
                next_idx[p]  = cand_idx[2*p];
            end else begin
                // tie without a match falls to the right
                next_load[p] = cand_load[2*p+1];
                next_idx[p]  = cand_idx[2*p+1];
            end
        end
    end

    // layer sequencing
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy  <= 1'b0;
            layer <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                layer <= '0;
            end else if (busy) begin
                layer <= layer + 1'b1;
                // result leaves on the edge of the last layer
                if (last_layer) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // snapshot and candidate buffer
    always_ff @(posedge aclk) begin
        if (start) begin
            stats_q <= region_stats;
            oid_q   <= req_oid;
            // every region starts as its own candidate
            for (int i = 0; i < lb_pkg::N_REGIONS; i++) begin
                cand_load[i] <= region_stats[i].load;
                cand_idx[i]  <= lb_pkg::region_idx_t'(i);
            end
        end else if (busy) begin
            // overwrite the low half, the upper half goes stale
            for (int p = 0; p < lb_pkg::N_PAIRS; p++) begin
                cand_load[p] <= next_load[p];
                cand_idx[p]  <= next_idx[p];
            end
        end
    end

    // slot 0 holds the survivor once the last layer is done
    // it stays put until the next start reloads the buffer
    assign winner = cand_idx[0];

endmodule

// ==== dispatch_ctrl.sv ====
`timescale 1ns/100ps

module dispatch_ctrl (
    input  logic                aclk,
    input  logic                aresetn,
    // queue head
    input  logic                head_valid,
    input  lb_pkg::meta_t       head_meta,
    output logic                pop,
    // search control
    output logic                start,
    output lb_pkg::oid_t        req_oid,
    input  logic                done,
    input  lb_pkg::region_idx_t winner,
    // proxy hand-off
    output logic                proxy_valid,
    input  logic                proxy_ready,
    output lb_pkg::meta_t       proxy_meta,
    output lb_pkg::region_idx_t lb_ctrl
);

    // idle waits for work, sched waits for the tree, offer waits for the proxy
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCHED,
        ST_OFFER
    } state_t;

    state_t state;

    // take the head word as soon as we are free
    // leaving idle on the same edge keeps this a single pulse
    assign pop = (state == ST_IDLE) && head_valid;

    // the search works on the latched request
    assign req_oid = proxy_meta[lb_pkg::META_OID_LSB +: lb_pkg::OID_BITS];

    // FSM and strobes
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= ST_IDLE;
            start       <= 1'b0;
            proxy_valid <= 1'b0;
        end else begin
            // start follows the pop edge, meta is latched by then
            start <= pop;
            case (state)
                ST_IDLE: begin
                    if (head_valid) begin
                        state <= ST_SCHED;
                    end
                end
                ST_SCHED: begin
                    if (done) begin
                        state       <= ST_OFFER;
                        proxy_valid <= 1'b1;
                    end
                end
                ST_OFFER: begin
                    // hold everything until the proxy takes it
                    if (proxy_ready) begin
                        state       <= ST_IDLE;
                        proxy_valid <= 1'b0;
                    end
                end
                default: begin
                    state       <= ST_IDLE;
                    proxy_valid <= 1'b0;
                end
            endcase
        end
    end

    // request and decision registers
    always_ff @(posedge aclk) begin
        if (pop) begin
            proxy_meta <= head_meta;
        end
        if ((state == ST_SCHED) && done) begin
            lb_ctrl <= winner;
        end
    end

endmodule

// ==== load_balancer.sv ====
`timescale 1ns/100ps

module load_balancer (
    input  logic                  aclk,
    input  logic                  aresetn,
    // request metadata in
    input  logic                  meta_in_valid,
    output logic                  meta_in_ready,
    input  lb_pkg::meta_t         meta_in_data,
    // live status of all regions
    input  lb_pkg::region_stats_t region_stats,
    // proxy side
    output logic                  proxy_valid,
    input  logic                  proxy_ready,
    output lb_pkg::meta_t         proxy_meta,
    output lb_pkg::region_idx_t   lb_ctrl
);

    // queue head to controller
    logic                head_valid;
    lb_pkg::meta_t       head_meta;
    logic                pop;

    // controller to tree and back
    logic                start;
    lb_pkg::oid_t        req_oid;
    logic                done;
    lb_pkg::region_idx_t winner;

    meta_fifo meta_fifo_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid   (meta_in_valid),
        .in_ready   (meta_in_ready),
        .in_meta    (meta_in_data),
        .head_valid (head_valid),
        .head_meta  (head_meta),
        .pop        (pop)
    );

    // stats are sampled by the tree on start, not by the controller
    least_load_tree least_load_tree_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .start        (start),
        .region_stats (region_stats),
        .req_oid      (req_oid),
        .done         (done),
        .winner       (winner)
    );

    dispatch_ctrl dispatch_ctrl_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .head_valid  (head_valid),
        .head_meta   (head_meta),
        .pop         (pop),
        .start       (start),
        .req_oid     (req_oid),
        .done        (done),
        .winner      (winner),
        .proxy_valid (proxy_valid),
        .proxy_ready (proxy_ready),
        .proxy_meta  (proxy_meta),
        .lb_ctrl     (lb_ctrl)
    );

endmodule

// ==== tb_load_balancer.sv ====
`timescale 1ns/100ps

module tb_load_balancer;

    localparam int N_DIRECTED = 9;
    localparam int N_RANDOM = 40;
    localparam int N_ROWS = N_DIRECTED + N_RANDOM;
    // longest any single wait may run in cycles
    localparam int WAIT_LIMIT = 200;
    localparam int BODY_BITS = lb_pkg::META_BITS - lb_pkg::OID_BITS;

    // one request with its region status, proxy stall and expected index
    typedef struct packed {
        logic [3:0]            test_id;
        lb_pkg::region_stats_t stats;
        lb_pkg::meta_t         meta;
        logic [7:0]            stall;
        lb_pkg::region_idx_t   exp_idx;
    } row_t;

    logic                  aclk;
    logic                  aresetn;
    logic                  meta_in_valid;
    logic                  meta_in_ready;
    lb_pkg::meta_t         meta_in_data;
    lb_pkg::region_stats_t region_stats;
    logic                  proxy_valid;
    logic                  proxy_ready;
    lb_pkg::meta_t         proxy_meta;
    lb_pkg::region_idx_t   lb_ctrl;

    row_t        table_rows [N_ROWS];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    load_balancer dut_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .meta_in_valid (meta_in_valid),
        .meta_in_ready (meta_in_ready),
        .meta_in_data  (meta_in_data),
        .region_stats  (region_stats),
        .proxy_valid   (proxy_valid),
        .proxy_ready   (proxy_ready),
        .proxy_meta    (proxy_meta),
        .lb_ctrl       (lb_ctrl)
    );

    // 40 ns clock
    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic lb_pkg::region_stats_t make_stats(
        input lb_pkg::load_t l0, input lb_pkg::load_t l1,
        input lb_pkg::load_t l2, input lb_pkg::load_t l3,
        input lb_pkg::oid_t o0, input lb_pkg::oid_t o1,
        input lb_pkg::oid_t o2, input lb_pkg::oid_t o3
    );
        lb_pkg::region_stats_t s;
        s[0].load = l0;
        s[0].oid  = o0;
        s[1].load = l1;
        s[1].oid  = o1;
        s[2].load = l2;
        s[2].oid  = o2;
        s[3].load = l3;
        s[3].oid  = o3;
        return s;
    endfunction

    // operator id sits in the low bits of the word
    function automatic lb_pkg::meta_t make_meta(input logic [BODY_BITS-1:0] body,
                                               input lb_pkg::oid_t oid);
        return {body, oid};
    endfunction

    // lower load wins and a tie goes left only on an operator match
    function automatic lb_pkg::region_idx_t pair_winner(input lb_pkg::region_stats_t s,
                                                        input lb_pkg::oid_t req,
                                                        input lb_pkg::region_idx_t a,
                                                        input lb_pkg::region_idx_t b);
        if (s[a].load < s[b].load) begin
            return a;
        end
        if (s[b].load < s[a].load) begin
            return b;
        end
        if (s[a].oid == req) begin
            return a;
        end
        return b;
    endfunction

    // expected region from pairs 0/1 and 2/3 and then the two survivors
    function automatic lb_pkg::region_idx_t pick_region(input lb_pkg::region_stats_t s,
                                                        input lb_pkg::oid_t req);
        lb_pkg::region_idx_t left;
        lb_pkg::region_idx_t right;
        left  = pair_winner(s, req, 2'd0, 2'd1);
        right = pair_winner(s, req, 2'd2, 2'd3);
        return pair_winner(s, req, left, right);
    endfunction

    task automatic set_row(input int idx, input logic [3:0] test_id,
                           input lb_pkg::region_stats_t s, input lb_pkg::meta_t m,
                           input logic [7:0] stall, input lb_pkg::region_idx_t exp_idx);
        table_rows[idx].test_id = test_id;
        table_rows[idx].stats   = s;
        table_rows[idx].meta    = m;
        table_rows[idx].stall   = stall;
        table_rows[idx].exp_idx = exp_idx;
    endtask

    task automatic fill_table();
        lb_pkg::region_stats_t s;
        lb_pkg::oid_t          req;
        logic [31:0]           r0;
        logic [31:0]           r1;
        logic [31:0]           r2;
        logic [31:0]           r3;
        int                    k;
        // unique minimum
        set_row(0, 4'd1, make_stats(4'd7, 4'd3, 4'd9, 4'd5, 16'h0011, 16'h0022, 16'h0033,
                16'h0044), make_meta(82'h1_2345_6789_abcd_ef01_2345, 16'h00aa), 8'd0, 2'd1);
        set_row(1, 4'd1, make_stats(4'd2, 4'd8, 4'd8, 4'd8, 16'h0011, 16'h0022, 16'h0033,
                16'h0044), make_meta(82'h2_0000_ffff_0000_ffff_0000, 16'h0022), 8'd0, 2'd0);
        set_row(2, 4'd1, make_stats(4'd9, 4'd9, 4'd9, 4'd1, 16'h0011, 16'h0022, 16'h0033,
                16'h0044), make_meta(82'h3_dead_beef_cafe_f00d_0bad, 16'h0011), 8'd0, 2'd3);
        // tie in layer 0 where the left region runs the operator
        set_row(3, 4'd2, make_stats(4'd2, 4'd2, 4'd6, 4'd6, 16'h1234, 16'h5555, 16'h7777,
                16'h7777), make_meta(82'h0_1111_2222_3333_4444_5555, 16'h1234), 8'd0, 2'd0);
        set_row(4, 4'd2, make_stats(4'd6, 4'd6, 4'd2, 4'd2, 16'h0101, 16'h0202, 16'h0303,
                16'h0404), make_meta(82'h1_aaaa_bbbb_cccc_dddd_eeee, 16'h0303), 8'd0, 2'd2);
        // tie in layer 1 between survivors 0 and 3
        set_row(5, 4'd2, make_stats(4'd3, 4'd5, 4'd5, 4'd3, 16'hbeef, 16'h0001, 16'h0002,
                16'h0003), make_meta(82'h2_5a5a_a5a5_5a5a_a5a5_5a5a, 16'hbeef), 8'd0, 2'd0);
        // all loads equal and nothing matches so the right side wins twice
        set_row(6, 4'd3, make_stats(4'd4, 4'd4, 4'd4, 4'd4, 16'h0001, 16'h0002, 16'h0003,
                16'h0004), make_meta(82'h0_0f0f_0f0f_0f0f_0f0f_0f0f, 16'h00ff), 8'd0, 2'd3);
        set_row(7, 4'd3, make_stats(4'd0, 4'd0, 4'd0, 4'd0, 16'haaaa, 16'haaaa, 16'haaaa,
                16'haaaa), make_meta(82'h3_f0f0_f0f0_f0f0_f0f0_f0f0, 16'h5555), 8'd0, 2'd3);
        // proxy stalls for six cycles
        set_row(8, 4'd4, make_stats(4'd5, 4'd1, 4'd5, 4'd5, 16'h0011, 16'h0022, 16'h0033,
                16'h0044), make_meta(82'h1_0123_4567_89ab_cdef_0123, 16'h0022), 8'd6, 2'd1);
        // random rows keep loads small so ties are common
        for (k = N_DIRECTED; k < N_ROWS; k++) begin
            r0 = lcg_next();
            r1 = lcg_next();
            r2 = lcg_next();
            r3 = lcg_next();
            s = make_stats({2'b00, r0[17:16]}, {2'b00, r0[19:18]},
                           {2'b00, r0[21:20]}, {2'b00, r0[23:22]},
                           {14'h0300, r1[17:16]}, {14'h0300, r1[19:18]},
                           {14'h0300, r1[21:20]}, {14'h0300, r1[23:22]});
            // half of the request ids match no region at all
            req = {13'h0180, r1[26:24]};
            set_row(k, 4'd6, s, make_meta({r2, r3, r0[31:14]}, req),
                    {6'd0, r1[29:28]}, pick_region(s, req));
        end
    endtask

    task automatic report_mismatch(input string name, input lb_pkg::meta_t got,
                                   input lb_pkg::meta_t exp);
        $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input logic [3:0] test_id, input string label,
                               input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s passed", test_id, label);
        end else begin
            tests_failed++;
            $display("test %0d %s failed with %0d errors", test_id, label, errors - err_before);
        end
    endtask

    // hold valid until the word is taken
    // entered and left on a falling edge
    task automatic push_meta(input lb_pkg::meta_t m);
        int wait_cnt;
        meta_in_valid = 1'b1;
        meta_in_data  = m;
        wait_cnt = 0;
        while (!meta_in_ready && wait_cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            wait_cnt++;
        end
        if (!meta_in_ready) begin
            $display("ERROR t=%0t request was never accepted, meta_in_ready stayed low", $time);
            errors++;
        end
        @(negedge aclk);
        meta_in_valid = 1'b0;
    endtask

    task automatic wait_offer(output logic seen);
        int wait_cnt;
        wait_cnt = 0;
        while (!proxy_valid && wait_cnt < WAIT_LIMIT) begin
            @(negedge aclk);
            wait_cnt++;
        end
        seen = proxy_valid;
        if (!seen) begin
            $display("ERROR t=%0t timed out waiting for proxy_valid", $time);
            errors++;
        end
    endtask

    // one cycle of proxy_ready completes the hand-off
    task automatic release_proxy();
        proxy_ready = 1'b1;
        @(negedge aclk);
        proxy_ready = 1'b0;
        checks++;
        if (proxy_valid) begin
            $display("ERROR t=%0t proxy_valid stayed high after the transfer", $time);
            errors++;
        end
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        logic seen;
        int   err_before;
        int   c;
        row = table_rows[idx];
        err_before = errors;
        // stats stay put until the next row
        region_stats = row.stats;
        push_meta(row.meta);
        wait_offer(seen);
        if (seen) begin
            checks++;
            if (proxy_meta !== row.meta) begin
                report_mismatch("proxy_meta", proxy_meta, row.meta);
            end
            checks++;
            if (lb_ctrl !== row.exp_idx) begin
                report_mismatch("lb_ctrl", lb_pkg::meta_t'(lb_ctrl),
                                lb_pkg::meta_t'(row.exp_idx));
            end
            // offer must not move while the proxy stalls
            for (c = 0; c < int'(row.stall); c++) begin
                @(negedge aclk);
                checks++;
                if (proxy_valid !== 1'b1) begin
                    $display("ERROR t=%0t proxy_valid dropped before the proxy accepted", $time);
                    errors++;
                end
                checks++;
                if (proxy_meta !== row.meta) begin
                    report_mismatch("proxy_meta", proxy_meta, row.meta);
                end
                checks++;
                if (lb_ctrl !== row.exp_idx) begin
                    report_mismatch("lb_ctrl", lb_pkg::meta_t'(lb_ctrl),
                                    lb_pkg::meta_t'(row.exp_idx));
                end
            end
            release_proxy();
        end
        finish_test(row.test_id, $sformatf("row %0d", idx), err_before);
    endtask

    // fill queue and controller with the proxy stalled and then drain in order
    task automatic run_queue_test();
        lb_pkg::meta_t         sent [$];
        lb_pkg::oid_t          reqs [$];
        lb_pkg::meta_t         m;
        lb_pkg::oid_t          req;
        lb_pkg::region_stats_t s;
        lb_pkg::region_idx_t   exp_idx;
        logic [31:0]           r0;
        logic [31:0]           r1;
        logic                  seen;
        int                    n;
        int                    k;
        int                    err_before;
        err_before = errors;
        s = make_stats(4'd5, 4'd5, 4'd5, 4'd5, 16'h0a01, 16'h0a02, 16'h0a03, 16'h0a04);
        region_stats = s;
        proxy_ready = 1'b0;
        n = 0;
        while (meta_in_ready && n < lb_pkg::QDEPTH + 3) begin
            r0 = lcg_next();
            r1 = lcg_next();
            // ids cycle through all four regions and one that matches none
            req = 16'h0a01 + 16'(n % 5);
            m = make_meta({r0, r1, r0[17:0]}, req);
            meta_in_valid = 1'b1;
            meta_in_data  = m;
            sent.push_back(m);
            reqs.push_back(req);
            n++;
            @(negedge aclk);
        end
        meta_in_valid = 1'b0;
        checks++;
        if (meta_in_ready) begin
            $display("ERROR t=%0t meta_in_ready still high after %0d requests", $time, n);
            errors++;
        end else if (n != lb_pkg::QDEPTH + 1) begin
            $display("ERROR t=%0t meta_in_ready fell after %0d requests instead of %0d",
                     $time, n, lb_pkg::QDEPTH + 1);
            errors++;
        end
        for (k = 0; k < n; k++) begin
            wait_offer(seen);
            if (!seen) begin
                break;
            end
            m = sent[k];
            exp_idx = pick_region(s, reqs[k]);
            checks++;
            if (proxy_meta !== m) begin
                report_mismatch("proxy_meta", proxy_meta, m);
            end
            checks++;
            if (lb_ctrl !== exp_idx) begin
                report_mismatch("lb_ctrl", lb_pkg::meta_t'(lb_ctrl), lb_pkg::meta_t'(exp_idx));
            end
            release_proxy();
        end
        finish_test(4'd5, $sformatf("queue of %0d requests", n), err_before);
    endtask

    initial begin
        int r;
        rng_state     = 32'd76;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        aresetn       = 1'b0;
        meta_in_valid = 1'b0;
        meta_in_data  = '0;
        region_stats  = '0;
        proxy_ready   = 1'b0;
        fill_table();
        // reset low for two rising edges
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        checks++;
        if (!meta_in_ready || proxy_valid) begin
            $display("ERROR t=%0t balancer not idle after reset", $time);
            errors++;
        end
        for (r = 0; r < N_DIRECTED; r++) begin
            apply_row(r);
        end
        run_queue_test();
        for (r = N_DIRECTED; r < N_ROWS; r++) begin
            apply_row(r);
        end
        @(negedge aclk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
lb_pkg.sv
meta_fifo.sv
least_load_tree.sv
dispatch_ctrl.sv
load_balancer.sv
tb_load_balancer.sv

// ==== Makefile ====
# Verilator flow for the request load balancer

VERILATOR  ?= verilator
TOP        ?= tb_load_balancer
DUT_TOP    ?= load_balancer
FILELIST   ?= project.f
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

# lint the design on its own, then with the testbench on top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and pass only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
